//--- verilog/axi_mem_pkg.sv
package axi_mem_pkg;

    localparam int ID_WIDTH   = 6;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // read address, top id bit names the source cache
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
    } ar_chan_t;

    // write address
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
    } aw_chan_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        logic [1:0]          resp;
    } b_chan_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } r_chan_t;

    // snoop request
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [3:0]            snoop;
    } ac_chan_t;

endpackage

//--- verilog/axi_chan_reg.sv
`timescale 1ns/100ps

module axi_chan_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t in,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out,
    output logic     out_valid,
    input  logic     out_ready
);

    // accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= in;
        end
    end

    // held item must survive back-pressure unchanged
    assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out)
    ) else $error("axi_chan_reg: held item changed under back-pressure");

endmodule

//--- verilog/axi_interconnect.sv
`timescale 1ns/100ps

module axi_interconnect #(
    parameter int ID_WIDTH = axi_mem_pkg::ID_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,

    // instruction cache
    input  axi_mem_pkg::ar_chan_t ic_ar,
    input  logic                  ic_ar_valid,
    output logic                  ic_ar_ready,
    output axi_mem_pkg::r_chan_t  ic_r,
    output logic                  ic_r_valid,
    input  logic                  ic_r_ready,
    output axi_mem_pkg::ac_chan_t ic_ac,
    output logic                  ic_ac_valid,
    input  logic                  ic_ac_ready,

    // data cache
    input  axi_mem_pkg::ar_chan_t dc_ar,
    input  logic                  dc_ar_valid,
    output logic                  dc_ar_ready,
    input  axi_mem_pkg::aw_chan_t dc_aw,
    input  logic                  dc_aw_valid,
    output logic                  dc_aw_ready,
    input  axi_mem_pkg::w_chan_t  dc_w,
    input  logic                  dc_w_valid,
    output logic                  dc_w_ready,
    output axi_mem_pkg::b_chan_t  dc_b,
    output logic                  dc_b_valid,
    input  logic                  dc_b_ready,
    output axi_mem_pkg::r_chan_t  dc_r,
    output logic                  dc_r_valid,
    input  logic                  dc_r_ready,
    output axi_mem_pkg::ac_chan_t dc_ac,
    output logic                  dc_ac_valid,
    input  logic                  dc_ac_ready,

    // snoop source
    input  axi_mem_pkg::ac_chan_t ac,
    input  logic                  ac_valid,
    output logic                  ac_ready,

    // memory side
    output axi_mem_pkg::ar_chan_t m_ar,
    output logic                  m_ar_valid,
    input  logic                  m_ar_ready,
    output axi_mem_pkg::aw_chan_t m_aw,
    output logic                  m_aw_valid,
    input  logic                  m_aw_ready,
    output axi_mem_pkg::w_chan_t  m_w,
    output logic                  m_w_valid,
    input  logic                  m_w_ready,
    input  axi_mem_pkg::b_chan_t  m_b,
    input  logic                  m_b_valid,
    output logic                  m_b_ready,
    input  axi_mem_pkg::r_chan_t  m_r,
    input  logic                  m_r_valid,
    output logic                  m_r_ready
);

    logic ar_lock;
    logic ar_lock_dc;
    logic ar_sel_dc;
    logic r_to_dc;
    logic ic_ack;
    logic dc_ack;

    // icache wins unless a grant is already held
    assign ar_sel_dc = ar_lock ? ar_lock_dc : !ic_ar_valid;

    always_comb begin
        m_ar = ar_sel_dc ? dc_ar : ic_ar;
        m_ar.id[ID_WIDTH-1] = ar_sel_dc;
    end

    assign m_ar_valid  = ar_sel_dc ? dc_ar_valid : ic_ar_valid;
    assign ic_ar_ready = !ar_sel_dc && m_ar_ready;
    assign dc_ar_ready = ar_sel_dc && m_ar_ready;

    // keep the winner until its address is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_lock    <= 1'b0;
            ar_lock_dc <= 1'b0;
        end else if (m_ar_valid && m_ar_ready) begin
            ar_lock <= 1'b0;
        end else if (m_ar_valid && !ar_lock) begin
            ar_lock    <= 1'b1;
            ar_lock_dc <= ar_sel_dc;
        end
    end

    // read data steered by id top bit
    assign r_to_dc    = m_r.id[ID_WIDTH-1];
    assign ic_r       = m_r;
    assign dc_r       = m_r;
    assign ic_r_valid = m_r_valid && !r_to_dc;
    assign dc_r_valid = m_r_valid && r_to_dc;
    assign m_r_ready  = r_to_dc ? dc_r_ready : ic_r_ready;

    // writes only from the dcache
    assign m_aw        = dc_aw;
    assign m_aw_valid  = dc_aw_valid;
    assign dc_aw_ready = m_aw_ready;
    assign m_w         = dc_w;
    assign m_w_valid   = dc_w_valid;
    assign dc_w_ready  = m_w_ready;
    assign dc_b        = m_b;
    assign dc_b_valid  = m_b_valid;
    assign m_b_ready   = dc_b_ready;

    // snoop broadcast where each cache acks once
    assign ic_ac       = ac;
    assign dc_ac       = ac;
    assign ic_ac_valid = ac_valid && !ic_ack;
    assign dc_ac_valid = ac_valid && !dc_ack;
    assign ac_ready    = ic_ack && dc_ack;

    always_ff @(posedge clk) begin
        if (rst || (ic_ack && dc_ack)) begin
            ic_ack <= 1'b0;
            dc_ack <= 1'b0;
        end else begin
            if (ic_ac_valid && ic_ac_ready) begin
                ic_ack <= 1'b1;
            end
            if (dc_ac_valid && dc_ac_ready) begin
                dc_ack <= 1'b1;
            end
        end
    end

    // pending address must not switch source or payload
    assert property (
        @(posedge clk) disable iff (rst)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar)
    ) else $error("axi_interconnect: pending read address changed before handshake");

    // snoop source holds ac_valid until it sees ac_ready
    assert property (
        @(posedge clk) disable iff (rst)
        ac_ready |-> ac_valid
    ) else $error("axi_interconnect: ac_ready without ac_valid");

endmodule

//--- verilog/axi_mem_slave.sv
`timescale 1ns/100ps

module axi_mem_slave #(
    parameter int ADDR_WIDTH = axi_mem_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = axi_mem_pkg::DATA_WIDTH,
    parameter int DEPTH      = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  axi_mem_pkg::ar_chan_t ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output axi_mem_pkg::r_chan_t  r,
    output logic                  r_valid,
    input  logic                  r_ready,

    input  axi_mem_pkg::aw_chan_t aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_mem_pkg::w_chan_t  w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output axi_mem_pkg::b_chan_t  b,
    output logic                  b_valid,
    input  logic                  b_ready
);

    import axi_mem_pkg::*;

    localparam int STRB_W   = DATA_WIDTH / 8;
    localparam int OFF_BITS = $clog2(STRB_W);
    localparam int WIDX_W   = ADDR_WIDTH - OFF_BITS;
    localparam int IDX_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic              ar_fire;
    logic              r_fire;
    logic              rd_active;
    logic [WIDX_W-1:0] rd_idx;
    logic [WIDX_W-1:0] rd_next;
    logic              rd_ok;
    logic [7:0]        rd_left;

    logic              aw_fire;
    logic              w_fire;
    logic              wr_active;
    logic [WIDX_W-1:0] wr_idx;
    logic              wr_ok;
    logic [7:0]        wr_left;
    logic              wr_err;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire  = r_valid && r_ready;

    // one read burst at a time
    assign ar_ready = !rd_active;
    assign r_valid  = rd_active;

    // word of the beat about to be presented
    assign rd_next = ar_fire ? ar.addr[ADDR_WIDTH-1:OFF_BITS] : rd_idx + 1'b1;
    assign rd_ok   = rd_next < DEPTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
        end else if (ar_fire) begin
            rd_active <= 1'b1;
        end else if (r_fire && r.last) begin
            rd_active <= 1'b0;
        end
    end

    // beat register, reloaded on accept and on each non-final beat
    always_ff @(posedge clk) begin
        if (ar_fire || (r_fire && !r.last)) begin
            rd_idx <= rd_next;
            r.data <= rd_ok ? mem[rd_next[IDX_W-1:0]] : '0;
            r.resp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            r.last <= ar_fire ? (ar.len == 8'd0) : (rd_left == 8'd1);
        end
        if (ar_fire) begin
            r.id    <= ar.id;
            rd_left <= ar.len;
        end else if (r_fire) begin
            rd_left <= rd_left - 8'd1;
        end
    end

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // new write only once the previous b has gone
    assign aw_ready = !wr_active && !b_valid;
    assign w_ready  = wr_active;
    assign wr_ok    = wr_idx < DEPTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_active <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (aw_fire) begin
                wr_active <= 1'b1;
            end else if (w_fire && w.last) begin
                wr_active <= 1'b0;
            end
            if (w_fire && w.last) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_idx  <= aw.addr[ADDR_WIDTH-1:OFF_BITS];
            wr_left <= aw.len;
            wr_err  <= 1'b0;
            b.id    <= aw.id;
        end else if (w_fire) begin
            wr_idx  <= wr_idx + 1'b1;
            wr_left <= wr_left - 8'd1;
            wr_err  <= wr_err || !wr_ok;
        end
        if (w_fire && w.last) begin
            b.resp <= (wr_err || !wr_ok) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // strobed byte write, out of range beats dropped
    always_ff @(posedge clk) begin
        if (w_fire && wr_ok) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx[IDX_W-1:0]][i*8 +: 8] <= w.data[i*8 +: 8];
                end
            end
        end
    end

    // wlast must match the length taken from aw
    assert property (
        @(posedge clk) disable iff (rst)
        w_fire |-> (w.last == (wr_left == 8'd0))
    ) else $error("axi_mem_slave: wlast disagrees with awlen");

endmodule

//--- verilog/axi_mem_subsys.sv
`timescale 1ns/100ps

module axi_mem_subsys #(
    parameter int ID_WIDTH   = axi_mem_pkg::ID_WIDTH,
    parameter int ADDR_WIDTH = axi_mem_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH = axi_mem_pkg::DATA_WIDTH,
    parameter int DEPTH      = 256
) (
    input  logic                  clk,
    input  logic                  rst,

    input  axi_mem_pkg::ar_chan_t ic_ar,
    input  logic                  ic_ar_valid,
    output logic                  ic_ar_ready,
    output axi_mem_pkg::r_chan_t  ic_r,
    output logic                  ic_r_valid,
    input  logic                  ic_r_ready,
    output axi_mem_pkg::ac_chan_t ic_ac,
    output logic                  ic_ac_valid,
    input  logic                  ic_ac_ready,

    input  axi_mem_pkg::ar_chan_t dc_ar,
    input  logic                  dc_ar_valid,
    output logic                  dc_ar_ready,
    input  axi_mem_pkg::aw_chan_t dc_aw,
    input  logic                  dc_aw_valid,
    output logic                  dc_aw_ready,
    input  axi_mem_pkg::w_chan_t  dc_w,
    input  logic                  dc_w_valid,
    output logic                  dc_w_ready,
    output axi_mem_pkg::b_chan_t  dc_b,
    output logic                  dc_b_valid,
    input  logic                  dc_b_ready,
    output axi_mem_pkg::r_chan_t  dc_r,
    output logic                  dc_r_valid,
    input  logic                  dc_r_ready,
    output axi_mem_pkg::ac_chan_t dc_ac,
    output logic                  dc_ac_valid,
    input  logic                  dc_ac_ready,

    input  axi_mem_pkg::ac_chan_t ac,
    input  logic                  ac_valid,
    output logic                  ac_ready
);

    import axi_mem_pkg::*;

    // interconnect side of the slices
    ar_chan_t m_ar;
    aw_chan_t m_aw;
    w_chan_t  m_w;
    b_chan_t  m_b;
    r_chan_t  m_r;
    logic     m_ar_valid, m_ar_ready, m_aw_valid, m_aw_ready;
    logic     m_w_valid, m_w_ready, m_b_valid, m_b_ready, m_r_valid, m_r_ready;

    // memory side of the slices
    ar_chan_t s_ar;
    aw_chan_t s_aw;
    w_chan_t  s_w;
    b_chan_t  s_b;
    r_chan_t  s_r;
    logic     s_ar_valid, s_ar_ready, s_aw_valid, s_aw_ready;
    logic     s_w_valid, s_w_ready, s_b_valid, s_b_ready, s_r_valid, s_r_ready;

    axi_interconnect #(
        .ID_WIDTH (ID_WIDTH)
    ) u_interconnect (
        .clk (clk), .rst (rst),
        .ic_ar (ic_ar), .ic_ar_valid (ic_ar_valid), .ic_ar_ready (ic_ar_ready),
        .ic_r  (ic_r),  .ic_r_valid  (ic_r_valid),  .ic_r_ready  (ic_r_ready),
        .ic_ac (ic_ac), .ic_ac_valid (ic_ac_valid), .ic_ac_ready (ic_ac_ready),
        .dc_ar (dc_ar), .dc_ar_valid (dc_ar_valid), .dc_ar_ready (dc_ar_ready),
        .dc_aw (dc_aw), .dc_aw_valid (dc_aw_valid), .dc_aw_ready (dc_aw_ready),
        .dc_w  (dc_w),  .dc_w_valid  (dc_w_valid),  .dc_w_ready  (dc_w_ready),
        .dc_b  (dc_b),  .dc_b_valid  (dc_b_valid),  .dc_b_ready  (dc_b_ready),
        .dc_r  (dc_r),  .dc_r_valid  (dc_r_valid),  .dc_r_ready  (dc_r_ready),
        .dc_ac (dc_ac), .dc_ac_valid (dc_ac_valid), .dc_ac_ready (dc_ac_ready),
        .ac    (ac),    .ac_valid    (ac_valid),    .ac_ready    (ac_ready),
        .m_ar  (m_ar),  .m_ar_valid  (m_ar_valid),  .m_ar_ready  (m_ar_ready),
        .m_aw  (m_aw),  .m_aw_valid  (m_aw_valid),  .m_aw_ready  (m_aw_ready),
        .m_w   (m_w),   .m_w_valid   (m_w_valid),   .m_w_ready   (m_w_ready),
        .m_b   (m_b),   .m_b_valid   (m_b_valid),   .m_b_ready   (m_b_ready),
        .m_r   (m_r),   .m_r_valid   (m_r_valid),   .m_r_ready   (m_r_ready)
    );

    // request path, one stage toward memory
    axi_chan_reg #(.payload_t(ar_chan_t)) u_ar_reg (
        .clk (clk), .rst (rst),
        .in  (m_ar), .in_valid  (m_ar_valid), .in_ready  (m_ar_ready),
        .out (s_ar), .out_valid (s_ar_valid), .out_ready (s_ar_ready)
    );

    axi_chan_reg #(.payload_t(aw_chan_t)) u_aw_reg (
        .clk (clk), .rst (rst),
        .in  (m_aw), .in_valid  (m_aw_valid), .in_ready  (m_aw_ready),
        .out (s_aw), .out_valid (s_aw_valid), .out_ready (s_aw_ready)
    );

    axi_chan_reg #(.payload_t(w_chan_t)) u_w_reg (
        .clk (clk), .rst (rst),
        .in  (m_w), .in_valid  (m_w_valid), .in_ready  (m_w_ready),
        .out (s_w), .out_valid (s_w_valid), .out_ready (s_w_ready)
    );

    // response path, one stage back toward the caches
    axi_chan_reg #(.payload_t(r_chan_t)) u_r_reg (
        .clk (clk), .rst (rst),
        .in  (s_r), .in_valid  (s_r_valid), .in_ready  (s_r_ready),
        .out (m_r), .out_valid (m_r_valid), .out_ready (m_r_ready)
    );

    axi_chan_reg #(.payload_t(b_chan_t)) u_b_reg (
        .clk (clk), .rst (rst),
        .in  (s_b), .in_valid  (s_b_valid), .in_ready  (s_b_ready),
        .out (m_b), .out_valid (m_b_valid), .out_ready (m_b_ready)
    );

    axi_mem_slave #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .DEPTH      (DEPTH)
    ) u_mem (
        .clk (clk), .rst (rst),
        .ar (s_ar), .ar_valid (s_ar_valid), .ar_ready (s_ar_ready),
        .r  (s_r),  .r_valid  (s_r_valid),  .r_ready  (s_r_ready),
        .aw (s_aw), .aw_valid (s_aw_valid), .aw_ready (s_aw_ready),
        .w  (s_w),  .w_valid  (s_w_valid),  .w_ready  (s_w_ready),
        .b  (s_b),  .b_valid  (s_b_valid),  .b_ready  (s_b_ready)
    );

endmodule

//--- verif/tb_axi_mem_subsys.sv
`timescale 1ns/100ps

module tb_axi_mem_subsys;

    import axi_mem_pkg::*;

    localparam int DEPTH = 256;

    logic     clk, rst;
    ar_chan_t ic_ar, dc_ar;
    aw_chan_t dc_aw;
    w_chan_t  dc_w;
    b_chan_t  dc_b;
    r_chan_t  ic_r, dc_r;
    ac_chan_t ac, ic_ac, dc_ac;
    logic     ic_ar_valid, ic_ar_ready, ic_r_valid, ic_r_ready, ic_ac_valid, ic_ac_ready;
    logic     dc_ar_valid, dc_ar_ready, dc_aw_valid, dc_aw_ready, dc_w_valid, dc_w_ready;
    logic     dc_b_valid, dc_b_ready, dc_r_valid, dc_r_ready, dc_ac_valid, dc_ac_ready;
    logic     ac_valid, ac_ready;

    logic [31:0] lcg_state = 32'd62;
    logic [7:0]  ref_mem [int];
    int          wr_start[$];
    int          wr_len[$];
    int          checks_done, errors_seen, base_checks, base_errors;
    int          cycle_count;
    int          cycle_limit = 40;
    int          ac_pulses;

    axi_mem_subsys #(
        .ID_WIDTH   (ID_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .DEPTH      (DEPTH)
    ) u_dut (
        .clk (clk), .rst (rst),
        .ic_ar (ic_ar), .ic_ar_valid (ic_ar_valid), .ic_ar_ready (ic_ar_ready),
        .ic_r  (ic_r),  .ic_r_valid  (ic_r_valid),  .ic_r_ready  (ic_r_ready),
        .ic_ac (ic_ac), .ic_ac_valid (ic_ac_valid), .ic_ac_ready (ic_ac_ready),
        .dc_ar (dc_ar), .dc_ar_valid (dc_ar_valid), .dc_ar_ready (dc_ar_ready),
        .dc_aw (dc_aw), .dc_aw_valid (dc_aw_valid), .dc_aw_ready (dc_aw_ready),
        .dc_w  (dc_w),  .dc_w_valid  (dc_w_valid),  .dc_w_ready  (dc_w_ready),
        .dc_b  (dc_b),  .dc_b_valid  (dc_b_valid),  .dc_b_ready  (dc_b_ready),
        .dc_r  (dc_r),  .dc_r_valid  (dc_r_valid),  .dc_r_ready  (dc_r_ready),
        .dc_ac (dc_ac), .dc_ac_valid (dc_ac_valid), .dc_ac_ready (dc_ac_ready),
        .ac    (ac),    .ac_valid    (ac_valid),    .ac_ready    (ac_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog, limit grows with every burst a test starts
    initial begin
        cycle_count = 0;
        while (cycle_count <= cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: no progress from the DUT after %0d cycles", cycle_count);
        $display("CHECKS FAILED");
        $finish;
    end

    always @(posedge clk) begin
        if (ac_ready) begin
            ac_pulses++;
        end
    end

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned bound);
        logic [31:0] x;
        x = rand_word();
        return x[31:8] % bound;
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks_done++;
        if (actual !== expected) begin
            errors_seen++;
            $display("error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_budget(input int len);
        cycle_limit += (len + 1 + 8) * 4;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks_done - base_checks, errors_seen - base_errors);
        base_checks = checks_done;
        base_errors = errors_seen;
    endtask

    // expected word from the byte model, mask covers the bytes known
    task automatic expected_beat(input int word, output logic [63:0] data,
                                 output logic [63:0] mask);
        int a;
        data = '0;
        mask = '0;
        if (word >= DEPTH) begin
            mask = '1;
        end else begin
            for (int i = 0; i < 8; i++) begin
                a = word * 8 + i;
                if (ref_mem.exists(a)) begin
                    data[i*8 +: 8] = ref_mem[a];
                    mask[i*8 +: 8] = 8'hff;
                end
            end
        end
    endtask

    task automatic send_ar(input bit to_dc, input ar_chan_t a);
        if (to_dc) begin
            dc_ar = a;
            dc_ar_valid = 1'b1;
            do @(posedge clk); while (!dc_ar_ready);
            #1 dc_ar_valid = 1'b0;
        end else begin
            ic_ar = a;
            ic_ar_valid = 1'b1;
            do @(posedge clk); while (!ic_ar_ready);
            #1 ic_ar_valid = 1'b0;
        end
    endtask

    task automatic set_r_ready(input bit to_dc, input bit bp);
        if (to_dc) begin
            dc_r_ready = bp ? (rand_below(4) != 0) : 1'b1;
        end else begin
            ic_r_ready = bp ? (rand_below(4) != 0) : 1'b1;
        end
    endtask

    task automatic collect_read(input bit to_dc, input logic [ID_WIDTH-1:0] id,
                                input int start, input int len, input bit bp,
                                output time first_t);
        r_chan_t             r;
        logic [63:0]         exp_data, mask;
        logic [ID_WIDTH-1:0] exp_id;
        logic                seen;
        int                  beat, word;
        beat = 0;
        first_t = 0;
        exp_id = id;
        exp_id[ID_WIDTH-1] = to_dc;
        set_r_ready(to_dc, bp);
        while (beat <= len) begin
            @(posedge clk);
            seen = to_dc ? (dc_r_valid && dc_r_ready) : (ic_r_valid && ic_r_ready);
            if (seen) begin
                r = to_dc ? dc_r : ic_r;
                if (beat == 0) begin
                    first_t = $time;
                end
                word = start + beat;
                expected_beat(word, exp_data, mask);
                check_value(r.data & mask, exp_data & mask,
                            $sformatf("read data word %0d", word));
                check_value(r.resp, (word < DEPTH) ? RESP_OKAY : RESP_SLVERR,
                            $sformatf("read resp word %0d", word));
                check_value(r.last, beat == len, $sformatf("rlast beat %0d", beat));
                check_value(r.id, exp_id, "rid");
                beat++;
            end
            #1 set_r_ready(to_dc, bp);
        end
        if (to_dc) begin
            dc_r_ready = 1'b0;
        end else begin
            ic_r_ready = 1'b0;
        end
    endtask

    task automatic read_burst(input bit to_dc, input int start, input int len,
                              input bit bp, output time first_t);
        ar_chan_t            a;
        logic [ID_WIDTH-1:0] id;
        id = ID_WIDTH'(rand_below(64));
        add_budget(len);
        a = '0;
        a.id = id;
        a.addr = start * 8;
        a.len = len;
        a.size = 3'd3;
        a.burst = 2'd1;
        fork
            send_ar(to_dc, a);
            collect_read(to_dc, id, start, len, bp, first_t);
        join
    endtask

    task automatic write_burst(input int start, input int len, input bit bp);
        aw_chan_t            aw;
        w_chan_t             w;
        logic [ID_WIDTH-1:0] id;
        logic [63:0]         data [8];
        logic [7:0]          strb [8];
        logic                done;
        int                  word;
        id = ID_WIDTH'(rand_below(64));
        add_budget(len);
        aw = '0;
        aw.id = id;
        aw.addr = start * 8;
        aw.len = len;
        aw.size = 3'd3;
        aw.burst = 2'd1;
        dc_aw = aw;
        dc_aw_valid = 1'b1;
        do @(posedge clk); while (!dc_aw_ready);
        #1 dc_aw_valid = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            data[beat] = {rand_word(), rand_word()};
            strb[beat] = 8'(rand_below(256));
            w.data = data[beat];
            w.strb = strb[beat];
            w.last = (beat == len);
            dc_w = w;
            dc_w_valid = 1'b1;
            do @(posedge clk); while (!dc_w_ready);
            #1;
        end
        dc_w_valid = 1'b0;
        done = 1'b0;
        dc_b_ready = bp ? (rand_below(3) != 0) : 1'b1;
        while (!done) begin
            @(posedge clk);
            if (dc_b_valid && dc_b_ready) begin
                check_value(dc_b.id, id, "bid");
                check_value(dc_b.resp, (start + len >= DEPTH) ? RESP_SLVERR : RESP_OKAY,
                            $sformatf("bresp burst at word %0d", start));
                done = 1'b1;
            end
            #1 dc_b_ready = bp ? (rand_below(3) != 0) : 1'b1;
        end
        dc_b_ready = 1'b0;
        // only in-range beats land in memory
        for (int beat = 0; beat <= len; beat++) begin
            word = start + beat;
            for (int i = 0; i < 8; i++) begin
                if (word < DEPTH && strb[beat][i]) begin
                    ref_mem[word * 8 + i] = data[beat][i*8 +: 8];
                end
            end
        end
        if (start + len < DEPTH) begin
            wr_start.push_back(start);
            wr_len.push_back(len);
        end
    endtask

    task automatic ack_snoop(input bit to_dc, input int delay, input ac_chan_t s,
                             output time t);
        ac_chan_t seen;
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        if (to_dc) begin
            dc_ac_ready = 1'b1;
            do @(posedge clk); while (!dc_ac_valid);
            seen = dc_ac;
        end else begin
            ic_ac_ready = 1'b1;
            do @(posedge clk); while (!ic_ac_valid);
            seen = ic_ac;
        end
        t = $time;
        check_value(seen, s, to_dc ? "dcache snoop payload" : "icache snoop payload");
        #1;
        dc_ac_ready = to_dc ? 1'b0 : dc_ac_ready;
        ic_ac_ready = to_dc ? ic_ac_ready : 1'b0;
    endtask

    task automatic run_snoop();
        ac_chan_t s;
        time      ic_t, dc_t, rdy_t, later;
        s.addr = rand_word();
        s.snoop = 4'(rand_below(16));
        add_budget(0);
        ac = s;
        ac_valid = 1'b1;
        fork
            ack_snoop(1'b0, rand_below(6), s, ic_t);
            ack_snoop(1'b1, rand_below(6), s, dc_t);
            begin
                do @(posedge clk); while (!ac_ready);
                rdy_t = $time;
                #1 ac_valid = 1'b0;
            end
        join
        later = (ic_t > dc_t) ? ic_t : dc_t;
        check_value(rdy_t, later + 4, "ac_ready one cycle after the later acknowledge");
    endtask

    initial begin
        time t_ic, t_dc;
        int  start, len, k, j;
        rst = 1'b1;
        ic_ar = '0;
        dc_ar = '0;
        dc_aw = '0;
        dc_w = '0;
        ac = '0;
        {ic_ar_valid, ic_r_ready, ic_ac_ready} = '0;
        {dc_ar_valid, dc_aw_valid, dc_w_valid, dc_b_ready, dc_r_ready, dc_ac_ready} = '0;
        ac_valid = 1'b0;
        {checks_done, errors_seen, base_checks, base_errors, ac_pulses} = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        for (int n = 0; n < 6; n++) begin
            start = rand_below(DEPTH - 8);
            len = rand_below(8);
            write_burst(start, len, 1'b0);
            read_burst(1'b1, start, len, 1'b0, t_dc);
        end
        report_test(1, "dcache write and read back");

        for (int n = 0; n < 6; n++) begin
            k = rand_below(wr_start.size());
            read_burst(1'b0, wr_start[k], wr_len[k], 1'b0, t_ic);
        end
        report_test(2, "icache reads");

        for (int n = 0; n < 4; n++) begin
            k = rand_below(wr_start.size());
            j = rand_below(wr_start.size());
            fork
                read_burst(1'b0, wr_start[k], wr_len[k], 1'b0, t_ic);
                read_burst(1'b1, wr_start[j], wr_len[j], 1'b0, t_dc);
            join
            check_value(t_ic < t_dc, 1'b1, "icache first beat ahead of dcache first beat");
        end
        report_test(3, "concurrent reads");

        for (int n = 0; n < 6; n++) begin
            start = rand_below(DEPTH - 8);
            len = rand_below(8);
            write_burst(start, len, 1'b1);
            k = rand_below(wr_start.size());
            j = rand_below(wr_start.size());
            fork
                read_burst(1'b0, wr_start[k], wr_len[k], 1'b1, t_ic);
                read_burst(1'b1, wr_start[j], wr_len[j], 1'b1, t_dc);
            join
        end
        report_test(4, "back-pressure");

        for (int n = 0; n < 3; n++) begin
            start = DEPTH - 1 - rand_below(3);
            len = 3 + rand_below(5);
            write_burst(start, len, 1'b0);
            read_burst(1'b1, start, len, 1'b0, t_dc);
            // word index wraps onto a written burst if the decode aliases
            k = rand_below(wr_start.size());
            write_burst(wr_start[k] + DEPTH, wr_len[k], 1'b0);
            read_burst(1'b0, wr_start[k] + DEPTH, wr_len[k], 1'b0, t_ic);
            read_burst(1'b0, wr_start[k], wr_len[k], 1'b0, t_ic);
        end
        report_test(5, "out of range");

        ac_pulses = 0;
        for (int n = 0; n < 5; n++) begin
            run_snoop();
        end
        repeat (2) @(posedge clk);
        #1 check_value(ac_pulses, 5, "ac_ready pulse count");
        report_test(6, "snoop fan-out");

        $display("total: %0d checks, %0d errors", checks_done, errors_seen);
        if (errors_seen == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/axi_mem_pkg.sv
verilog/axi_chan_reg.sv
verilog/axi_interconnect.sv
verilog/axi_mem_slave.sv
verilog/axi_mem_subsys.sv
verif/tb_axi_mem_subsys.sv

//--- Bender.yml
package:
  name: axi_mem_subsys

sources:
  - files:
      - verilog/axi_mem_pkg.sv
      - verilog/axi_chan_reg.sv
      - verilog/axi_interconnect.sv
      - verilog/axi_mem_slave.sv
      - verilog/axi_mem_subsys.sv
  - target: test
    files:
      - verif/tb_axi_mem_subsys.sv
